// File: common/thrd_pkg.sv
package thrd_pkg;

  // thread entry address and data word widths
  localparam int THRD_ADDR_W = 16;
  localparam int THRD_DATA_W = 32;

  // client command opcode
  typedef enum logic {
    THRD_RUN  = 1'b0,
    THRD_STOP = 1'b1
  } thrd_op_e;

  // command as it travels from the client to the table
  typedef struct packed {
    thrd_op_e               op;
    logic [THRD_ADDR_W-1:0] addr;
    logic [THRD_DATA_W-1:0] data;
  } thrd_cmd_t;

  // command result, op echoed back
  typedef struct packed {
    thrd_op_e op;
    logic     ok;
  } thrd_rslt_t;

  // one thread as held in a table slot
  typedef struct packed {
    logic [THRD_ADDR_W-1:0] addr;
    logic [THRD_DATA_W-1:0] data;
  } thrd_entry_t;

  // dispatch response
  // idle set when no thread is held at all
  typedef struct packed {
    logic        idle;
    thrd_entry_t entry;
  } thrd_next_t;

endpackage

// File: hw/thrd_cmd_stage.sv
`timescale 1ns/1ps

module thrd_cmd_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  thrd_pkg::thrd_cmd_t in_cmd_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output thrd_pkg::thrd_cmd_t out_cmd_o
);

  logic in_fire;
  logic out_fire;

  // one entry: free if empty or if the held command leaves this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign in_fire    = in_valid_i && in_ready_o;
  assign out_fire   = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else begin
      if (in_fire) begin
        out_valid_o <= 1'b1;
      end else if (out_fire) begin
        out_valid_o <= 1'b0;
      end
    end
  end

  // payload register, only loaded on acceptance
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_cmd_o <= in_cmd_i;
    end
  end

endmodule

// File: hw/thrd_manager_top.sv
`timescale 1ns/1ps

module thrd_manager_top #(
  parameter int PROC_QUANTITY = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  thrd_pkg::thrd_cmd_t  cmd_i,
  output logic                 rslt_valid_o,
  input  logic                 rslt_ready_i,
  output thrd_pkg::thrd_rslt_t rslt_o,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output logic                 next_valid_o,
  input  logic                 next_ready_i,
  output thrd_pkg::thrd_next_t next_o
);

  localparam int IDX_W = $clog2(PROC_QUANTITY);

  // command stage to table
  logic                 stg_valid;
  logic                 stg_ready;
  thrd_pkg::thrd_cmd_t  stg_cmd;

  // scheduler to table
  logic                 pick;
  logic [IDX_W-1:0]     pick_last;
  thrd_pkg::thrd_next_t pick_next;
  logic [IDX_W-1:0]     pick_idx;

  thrd_cmd_stage cmd_stage0 (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (cmd_valid_i),
    .in_ready_o (cmd_ready_o),
    .in_cmd_i   (cmd_i),
    .out_valid_o(stg_valid),
    .out_ready_i(stg_ready),
    .out_cmd_o  (stg_cmd)
  );

  thrd_table #(
    .PROC_QUANTITY(PROC_QUANTITY)
  ) table0 (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid_i (stg_valid),
    .cmd_ready_o (stg_ready),
    .cmd_i       (stg_cmd),
    .rslt_valid_o(rslt_valid_o),
    .rslt_ready_i(rslt_ready_i),
    .rslt_o      (rslt_o),
    .pick_i      (pick),
    .pick_last_i (pick_last),
    .pick_o      (pick_next),
    .pick_idx_o  (pick_idx)
  );

  thrd_sched #(
    .PROC_QUANTITY(PROC_QUANTITY)
  ) sched0 (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .next_valid_o(next_valid_o),
    .next_ready_i(next_ready_i),
    .next_o      (next_o),
    .pick_o      (pick),
    .pick_last_o (pick_last),
    .pick_i      (pick_next),
    .pick_idx_i  (pick_idx)
  );

endmodule

// File: hw/thrd_sched.sv
`timescale 1ns/1ps

module thrd_sched #(
  parameter int PROC_QUANTITY = 8,
  localparam int IDX_W = $clog2(PROC_QUANTITY)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output logic                 next_valid_o,
  input  logic                 next_ready_i,
  output thrd_pkg::thrd_next_t next_o,
  output logic                 pick_o,
  output logic [IDX_W-1:0]     pick_last_o,
  input  thrd_pkg::thrd_next_t pick_i,
  input  logic [IDX_W-1:0]     pick_idx_i
);

  // index of the thread dispatched last
  logic [IDX_W-1:0] last_q;

  // response slot is free once the held one is taken
  assign req_ready_o = !next_valid_o || next_ready_i;

  // the table answers in the same cycle, so a pick is an accepted request
  assign pick_o      = req_valid_i && req_ready_o;
  assign pick_last_o = last_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      next_valid_o <= 1'b0;
      // search starts at slot 0 after reset
      last_q       <= IDX_W'(PROC_QUANTITY - 1);
    end else begin
      if (pick_o) begin
        next_valid_o <= 1'b1;
        // idle picks leave the pointer alone
        if (!pick_i.idle) begin
          last_q <= pick_idx_i;
        end
      end else if (next_ready_i) begin
        next_valid_o <= 1'b0;
      end
    end
  end

  // response payload, held until next_ready_i
  always_ff @(posedge clk) begin
    if (pick_o) begin
      next_o <= pick_i;
    end
  end

endmodule

// File: sim/tb_thrd_manager.sv
`timescale 1ns/1ps

module tb_thrd_manager;

  localparam int PQ = 8;
  localparam int N_OPS = 600;
  localparam int N_RAND = N_OPS - 40;
  localparam int OP_CYCLES = 12;
  localparam int MAX_CYCLES = N_OPS * OP_CYCLES + 800;
  // six addresses so that STOP finds matches often
  localparam logic [6*16-1:0] POOL = {16'h7f00, 16'h5a5a, 16'h3c00, 16'h2040, 16'h1200, 16'h0a10};

  logic                 clk;
  logic                 rst;
  logic                 cmd_valid;
  logic                 cmd_ready;
  thrd_pkg::thrd_cmd_t  cmd;
  logic                 rslt_valid;
  logic                 rslt_ready;
  thrd_pkg::thrd_rslt_t rslt;
  logic                 req_valid;
  logic                 req_ready;
  logic                 next_valid;
  logic                 next_ready;
  thrd_pkg::thrd_next_t nxt;

  logic [31:0]           lfsr;
  int                    cycles;
  logic [PQ-1:0]         m_occ;
  logic [PQ-1:0]         m_disp;
  thrd_pkg::thrd_entry_t m_slot [PQ];
  int                    m_fresh [$];
  int                    m_last;

  thrd_manager_top #(
    .PROC_QUANTITY(PQ)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .cmd_i       (cmd),
    .rslt_valid_o(rslt_valid),
    .rslt_ready_i(rslt_ready),
    .rslt_o      (rslt),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .next_valid_o(next_valid),
    .next_ready_i(next_ready),
    .next_o      (nxt)
  );

  bind thrd_manager_top thrd_manager_assertions asrt0 (
    .clk         (clk),
    .rst         (rst),
    .rslt_valid_i(rslt_valid_o),
    .rslt_ready_i(rslt_ready_i),
    .rslt_i      (rslt_o),
    .next_valid_i(next_valid_o),
    .next_ready_i(next_ready_i),
    .next_i      (next_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [thrd_pkg::THRD_ADDR_W-1:0] pool_addr(input int k);
    return POOL[k*16 +: 16];
  endfunction

  // reference model of one command
  function automatic thrd_pkg::thrd_rslt_t model_cmd(input thrd_pkg::thrd_cmd_t c);
    thrd_pkg::thrd_rslt_t r;
    r.op = c.op;
    r.ok = 1'b0;
    for (int i = 0; i < PQ; i++) begin
      if (c.op == thrd_pkg::THRD_RUN && !r.ok && !m_occ[i]) begin
        r.ok      = 1'b1;
        m_occ[i]  = 1'b1;
        m_disp[i] = 1'b0;
        m_slot[i] = '{addr: c.addr, data: c.data};
        m_fresh.push_back(i);
      end else if (c.op == thrd_pkg::THRD_STOP && m_occ[i] && m_disp[i]
                   && m_slot[i].addr == c.addr) begin
        r.ok      = 1'b1;
        m_occ[i]  = 1'b0;
        m_disp[i] = 1'b0;
      end
    end
    return r;
  endfunction

  // reference model of one pick, fresh first, then round robin
  function automatic thrd_pkg::thrd_next_t model_pick();
    thrd_pkg::thrd_next_t n;
    int                   j;
    int                   hit;
    n.idle  = 1'b1;
    n.entry = '0;
    hit     = -1;
    if (m_fresh.size() > 0) begin
      hit         = m_fresh.pop_front();
      m_disp[hit] = 1'b1;
    end else begin
      for (int k = 1; k <= PQ; k++) begin
        j = (m_last + k) % PQ;
        if (hit < 0 && m_occ[j] && m_disp[j]) begin
          hit = j;
        end
      end
    end
    if (hit >= 0) begin
      n.idle  = 1'b0;
      n.entry = m_slot[hit];
      m_last  = hit;
    end
    return n;
  endfunction

  task automatic check_rslt(input string name, input thrd_pkg::thrd_rslt_t exp,
                            input thrd_pkg::thrd_rslt_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected op=%0d ok=%0b, actual op=%0d ok=%0b",
               name, exp.op, exp.ok, act.op, act.ok);
      $display("Simulation failed");
      $fatal(1, "result mismatch");
    end
  endtask

  // entry is a don't care on idle responses
  task automatic check_next(input string name, input thrd_pkg::thrd_next_t exp,
                            input thrd_pkg::thrd_next_t act);
    if (act.idle !== exp.idle || (!exp.idle && act.entry !== exp.entry)) begin
      $display("[FAIL] %s: expected idle=%0b entry=%h, actual idle=%0b entry=%h",
               name, exp.idle, exp.entry, act.idle, act.entry);
      $display("Simulation failed");
      $fatal(1, "response mismatch");
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic send_cmd(input thrd_pkg::thrd_op_e op,
                          input logic [thrd_pkg::THRD_ADDR_W-1:0] addr, input string name);
    thrd_pkg::thrd_cmd_t  c;
    thrd_pkg::thrd_rslt_t exp;
    int                   hold;
    c.op       = op;
    c.addr     = addr;
    c.data     = rand_bits(32);
    exp        = model_cmd(c);
    hold       = int'(rand_bits(2));
    cmd        = c;
    cmd_valid  = 1'b1;
    rslt_ready = 1'b0;
    #1;
    while (!cmd_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    while (!rslt_valid) begin
      @(negedge clk);
    end
    // random stall on the result port
    repeat (hold) @(negedge clk);
    rslt_ready = 1'b1;
    check_rslt(name, exp, rslt);
    @(negedge clk);
    rslt_ready = 1'b0;
  endtask

  task automatic send_req(input string name);
    thrd_pkg::thrd_next_t exp;
    int                   hold;
    exp        = model_pick();
    hold       = int'(rand_bits(2));
    req_valid  = 1'b1;
    next_ready = 1'b0;
    #1;
    while (!req_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    req_valid = 1'b0;
    while (!next_valid) begin
      @(negedge clk);
    end
    repeat (hold) @(negedge clk);
    next_ready = 1'b1;
    check_next(name, exp, nxt);
    @(negedge clk);
    next_ready = 1'b0;
  endtask

  initial begin
    int kind;
    int sel;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    rslt_ready = 1'b0;
    req_valid  = 1'b0;
    next_ready = 1'b0;
    lfsr       = 32'h28d1_6c66;
    cycles     = 0;
    m_occ      = '0;
    m_disp     = '0;
    m_last     = PQ - 1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    send_req("reset_idle");
    send_cmd(thrd_pkg::THRD_STOP, pool_addr(0), "reset_stop");
    for (int i = 0; i < PQ; i++) begin
      send_cmd(thrd_pkg::THRD_RUN, pool_addr(i % 6), "fill_run");
    end
    send_cmd(thrd_pkg::THRD_RUN, pool_addr(1), "full_run");
    for (int i = 0; i < PQ; i++) begin
      send_req("fresh_order");
    end
    for (int i = 0; i < 10; i++) begin
      send_req("round_robin");
    end
    // slots 0 and 6 share this address
    send_cmd(thrd_pkg::THRD_STOP, pool_addr(0), "stop_hit");
    for (int i = 0; i < PQ; i++) begin
      send_req("after_stop");
    end
    send_cmd(thrd_pkg::THRD_RUN, 16'hbeef, "reuse_run");
    send_cmd(thrd_pkg::THRD_STOP, 16'hbeef, "stop_fresh");

    for (int n = 0; n < N_RAND; n++) begin
      kind = int'(rand_bits(2));
      sel  = int'(rand_bits(3)) % 6;
      if (kind < 2) begin
        send_req("random_req");
      end else if (kind == 2) begin
        send_cmd(thrd_pkg::THRD_RUN, pool_addr(sel), "random_run");
      end else begin
        send_cmd(thrd_pkg::THRD_STOP, pool_addr(sel), "random_stop");
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: sim/thrd_manager_assertions.sv
`timescale 1ns/1ps

module thrd_manager_assertions (
  input logic                 clk,
  input logic                 rst,
  input logic                 rslt_valid_i,
  input logic                 rslt_ready_i,
  input thrd_pkg::thrd_rslt_t rslt_i,
  input logic                 next_valid_i,
  input logic                 next_ready_i,
  input thrd_pkg::thrd_next_t next_i
);

  logic thread_held;

  // set by a successful RUN
  // a successful STOP may free the last thread, so it clears the flag
  always_ff @(posedge clk) begin
    if (rst) begin
      thread_held <= 1'b0;
    end else if (rslt_valid_i && rslt_i.ok) begin
      thread_held <= (rslt_i.op == thrd_pkg::THRD_RUN);
    end
  end

  // stalled result keeps valid and payload
  rslt_hold: assert property (@(posedge clk) disable iff (rst)
    rslt_valid_i && !rslt_ready_i |=> rslt_valid_i && (rslt_i === $past(rslt_i)))
    else $error("result changed while stalled");

  // same for the dispatch response
  next_hold: assert property (@(posedge clk) disable iff (rst)
    next_valid_i && !next_ready_i |=> next_valid_i && (next_i === $past(next_i)))
    else $error("dispatch response changed while stalled");

  // both output registers come out of reset empty
  reset_clear: assert property (@(posedge clk)
    $fell(rst) |-> !rslt_valid_i && !next_valid_i)
    else $error("output valid high right after reset");

  no_idle_while_held: assert property (@(posedge clk) disable iff (rst)
    next_valid_i && thread_held |-> !next_i.idle)
    else $error("idle response while a thread is held");

endmodule

// File: thrd_manager_top.f
common/thrd_pkg.sv
hw/thrd_cmd_stage.sv
thread_table/thrd_fresh_queue.sv
thread_table/thrd_table.sv
hw/thrd_sched.sv
hw/thrd_manager_top.sv
sim/thrd_manager_assertions.sv
sim/tb_thrd_manager.sv

// File: thread_table/thrd_fresh_queue.sv
`timescale 1ns/1ps

module thrd_fresh_queue #(
  parameter int DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH),
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push_i,
  input  logic [IDX_W-1:0] push_idx_i,
  input  logic             pop_i,
  output logic             empty_o,
  output logic [IDX_W-1:0] head_idx_o
);

  logic [IDX_W-1:0] mem [DEPTH];
  logic [IDX_W-1:0] wr_ptr;
  logic [IDX_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign empty_o    = (count == '0);
  assign head_idx_o = mem[rd_ptr];

  // pointers wrap explicitly, DEPTH need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == IDX_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == IDX_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_idx_i;
    end
  end

endmodule

// File: thread_table/thrd_table.sv
`timescale 1ns/1ps

module thrd_table #(
  parameter int PROC_QUANTITY = 8,
  localparam int IDX_W = $clog2(PROC_QUANTITY)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  thrd_pkg::thrd_cmd_t  cmd_i,
  output logic                 rslt_valid_o,
  input  logic                 rslt_ready_i,
  output thrd_pkg::thrd_rslt_t rslt_o,
  input  logic                 pick_i,
  input  logic [IDX_W-1:0]     pick_last_i,
  output thrd_pkg::thrd_next_t pick_o,
  output logic [IDX_W-1:0]     pick_idx_o
);

  thrd_pkg::thrd_entry_t    slots [PROC_QUANTITY];
  logic [PROC_QUANTITY-1:0] occ;
  logic [PROC_QUANTITY-1:0] disp;

  logic                     cmd_fire;
  logic                     is_run;
  logic                     free_found;
  logic [IDX_W-1:0]         free_idx;
  logic [PROC_QUANTITY-1:0] stop_hit;
  logic                     rr_found;
  logic [IDX_W-1:0]         rr_idx;

  logic                     fq_push;
  logic                     fq_pop;
  logic                     fq_empty;
  logic [IDX_W-1:0]         fq_head;

  // a pick owns the cycle; the command waits in the stage
  assign cmd_ready_o = (!rslt_valid_o || rslt_ready_i) && !pick_i;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;
  assign is_run      = (cmd_i.op == thrd_pkg::THRD_RUN);

  // lowest free slot
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = PROC_QUANTITY - 1; i >= 0; i--) begin
      if (!occ[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_W'(i);
      end
    end
  end

  // STOP only sees threads that were dispatched at least once
  always_comb begin
    for (int i = 0; i < PROC_QUANTITY; i++) begin
      stop_hit[i] = occ[i] && disp[i] && (slots[i].addr == cmd_i.addr);
    end
  end

  // round robin, first dispatched slot after the last one handed out
  always_comb begin
    int j;
    rr_found = 1'b0;
    rr_idx   = '0;
    for (int k = 1; k <= PROC_QUANTITY; k++) begin
      j = int'(pick_last_i) + k;
      if (j >= PROC_QUANTITY) begin
        j = j - PROC_QUANTITY;
      end
      if (!rr_found && occ[j] && disp[j]) begin
        rr_found = 1'b1;
        rr_idx   = IDX_W'(j);
      end
    end
  end

  // fresh threads always go first
  assign pick_idx_o     = !fq_empty ? fq_head : rr_idx;
  assign pick_o.idle    = fq_empty && !rr_found;
  assign pick_o.entry   = slots[pick_idx_o];

  assign fq_push = cmd_fire && is_run && free_found;
  assign fq_pop  = pick_i && !fq_empty;

  thrd_fresh_queue #(
    .DEPTH(PROC_QUANTITY)
  ) fresh_q0 (
    .clk       (clk),
    .rst       (rst),
    .push_i    (fq_push),
    .push_idx_i(free_idx),
    .pop_i     (fq_pop),
    .empty_o   (fq_empty),
    .head_idx_o(fq_head)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      occ          <= '0;
      disp         <= '0;
      rslt_valid_o <= 1'b0;
    end else begin
      if (cmd_fire) begin
        rslt_valid_o <= 1'b1;
        if (is_run) begin
          if (free_found) begin
            occ[free_idx]  <= 1'b1;
            disp[free_idx] <= 1'b0;
          end
        end else begin
          occ  <= occ & ~stop_hit;
          disp <= disp & ~stop_hit;
        end
      end else if (rslt_ready_i) begin
        rslt_valid_o <= 1'b0;
      end
      // fresh head becomes a round robin member
      if (fq_pop) begin
        disp[fq_head] <= 1'b1;
      end
    end
  end

  // slot contents and result payload
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      rslt_o.op <= cmd_i.op;
      rslt_o.ok <= is_run ? free_found : |stop_hit;
    end
    if (fq_push) begin
      slots[free_idx] <= '{addr: cmd_i.addr, data: cmd_i.data};
    end
  end

endmodule
